/* sim.f */
design/rv32i_types_pkg.sv
design/ooo_ctrl_pkg.sv
design/ooo_hazard_unit.sv
design/reg_scoreboard.sv
design/fu_busy_tracker.sv
design/completion_buffer.sv
design/prv_trap_ctrl.sv
design/ooo_issue_ctrl.sv
test/tb_ooo_issue_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_issue_ctrl
RTL_TOP   ?= ooo_issue_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= PASS: all tests

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(shell grep '^design/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_ooo_issue_ctrl.sv */
module tb_ooo_issue_ctrl
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES   = 4000;
  // every cycle of the run plus reset and some slack
  localparam int TIMEOUT      = (NUM_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD;

  logic        CLK;
  logic        rst_n;
  logic        issue_valid;
  issue_req_t  issue_req;
  logic        wb_valid;
  wb_req_t     wb_req;
  hazard_out_t hz;
  cb_tag_t     issue_tag;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic        insert_pc;
  logic [31:0] priv_pc;
  logic [31:0] mepc;
  logic [31:0] mcause;

  // reference model state, holds the value after the coming rising edge
  logic [31:0]         lfsr;
  logic [31:0]         next_pc;
  logic [31:0]         m_busy;
  int                  m_div_cnt;
  int                  m_ls_cnt;
  logic [31:0]         m_pc  [CB_DEPTH];
  exc_flags_t          m_exc [CB_DEPTH];
  reg_idx_t            m_rd  [CB_DEPTH];
  logic                m_wen [CB_DEPTH];
  logic [CB_DEPTH-1:0] m_valid;
  logic [CB_DEPTH-1:0] m_done;
  int                  m_head;
  int                  m_tail;
  int                  m_count;
  logic                m_mis_ff;
  logic                m_insert;
  logic [31:0]         m_mepc;
  logic [31:0]         m_mcause;

  // expected combinational values for the current cycle
  hazard_out_t e_hz;
  logic        e_fire;
  logic        e_retire;
  logic        e_flush;
  logic        e_data;
  logic        e_strct;
  logic        e_store;

  // event counts so the run proves it reached each behavior
  int n_data, n_strct, n_csr, n_store, n_full, n_commit, n_flush, n_redirect;

  ooo_issue_ctrl UUT (
    .CLK(CLK), .rst_n(rst_n), .issue_valid(issue_valid), .issue_req(issue_req),
    .wb_valid(wb_valid), .wb_req(wb_req), .hz(hz), .issue_tag(issue_tag),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .insert_pc(insert_pc),
    .priv_pc(priv_pc), .mepc(mepc), .mcause(mcause)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired before the random sequence completed");
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // mcause from the priority table of the trap controller
  function automatic logic [31:0] expected_cause(input exc_flags_t e);
    if (e.breakpoint)   return 32'd3;
    if (e.fault_insn)   return 32'd1;
    if (e.mal_insn)     return 32'd0;
    if (e.illegal_insn) return 32'd2;
    if (e.env_m)        return 32'd11;
    if (e.mal_l)        return 32'd4;
    if (e.fault_l)      return 32'd5;
    if (e.mal_s)        return 32'd6;
    return 32'd7;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // fill mode offers only independent alu and mul ops so the buffer fills up
  function automatic issue_req_t random_req(input logic fill);
    issue_req_t r;
    r.pc           = next_pc;
    next_pc        = next_pc + 32'd4;
    r.fu_type      = fu_type_t'(2'(take_bits(2)));
    r.source_a_sel = src_sel_t'(take_bits(2));
    r.source_b_sel = src_sel_t'(take_bits(2));
    r.rs1          = reg_idx_t'(take_bits(3));
    r.rs2          = reg_idx_t'(take_bits(3));
    r.rd           = reg_idx_t'(take_bits(3));
    r.wen          = (take_bits(1) != 0);
    r.csr          = (take_bits(4) == 0);
    r.branch       = (take_bits(1) != 0);
    r.mispredict   = (take_bits(2) == 0);
    if (fill) begin
      r.wen     = 1'b0;
      r.csr     = 1'b0;
      r.fu_type = fu_type_t'({1'b0, r.fu_type[0]});
    end
    return r;
  endfunction

  // writeback of a random outstanding tag, sometimes with exception flags
  task automatic pick_writeback(input logic fill);
    int          start;
    int          idx;
    logic        found;
    logic [8:0]  flags;
    wb_valid = 1'b0;
    wb_req   = '0;
    found    = 1'b0;
    idx      = 0;
    start    = int'(take_bits(3));
    if (!fill && take_bits(1) != 0) begin
      for (int i = 0; i < CB_DEPTH; i++) begin
        if (!found && m_valid[(start + i) % CB_DEPTH] && !m_done[(start + i) % CB_DEPTH]) begin
          found = 1'b1;
          idx   = (start + i) % CB_DEPTH;
        end
      end
    end
    if (found) begin
      wb_valid   = 1'b1;
      wb_req.tag = cb_tag_t'(idx);
      wb_req.rd  = m_rd[idx];
      wb_req.wen = m_wen[idx];
      flags      = '0;
      if (take_bits(5) == 0) begin
        flags = 9'd1 << (take_bits(4) % 9);
        if (take_bits(2) == 0) begin
          flags = flags | 9'(take_bits(9));
        end
      end
      wb_req.exc = exc_flags_t'(flags);
    end
  endtask

  task automatic clear_window();
    m_busy    = '0;
    m_div_cnt = 0;
    m_ls_cnt  = 0;
    m_valid   = '0;
    m_done    = '0;
    m_head    = 0;
    m_tail    = 0;
    m_count   = 0;
  endtask

  task automatic compute_expected();
    logic a_haz;
    logic b_haz;
    logic d_haz;
    logic stall;
    logic head_done;
    head_done = (m_count != 0) && m_done[m_head];
    e_retire  = head_done && (m_exc[m_head] == '0);
    e_flush   = head_done && (m_exc[m_head] != '0);
    // immediate and pc operands never wait on the scoreboard
    a_haz   = (issue_req.source_a_sel <= 2'd1) && m_busy[issue_req.rs1];
    b_haz   = (issue_req.source_b_sel <= 2'd1) && m_busy[issue_req.rs2];
    d_haz   = issue_req.wen && m_busy[issue_req.rd];
    e_data  = a_haz || b_haz || d_haz;
    e_strct = ((issue_req.fu_type == DIV_S) && (m_div_cnt > 0)) ||
              ((issue_req.fu_type == LOADSTORE_S) && (m_ls_cnt > 0));
    e_store = (issue_req.fu_type == LOADSTORE_S) && (issue_req.source_a_sel == 2'd1);
    stall   = issue_req.csr || (m_count == CB_DEPTH) || e_data || e_strct ||
              (e_store && (m_count != 0)) || m_mis_ff;
    e_fire  = issue_valid && !stall;
    e_hz.pc_en                = !stall;
    e_hz.stall_fetch_decode   = stall;
    e_hz.data_hazard          = e_data;
    e_hz.hazard               = e_data || e_strct;
    e_hz.npc_sel              = e_fire && issue_req.branch && issue_req.mispredict;
    e_hz.csr_flush            = issue_req.csr;
    e_hz.fetch_decode_flush   = e_hz.npc_sel || m_insert || issue_req.csr || e_flush;
    e_hz.decode_execute_flush = e_hz.npc_sel || m_insert || e_flush;
    e_hz.execute_commit_flush = issue_req.csr || e_flush;
  endtask

  task automatic compare_outputs();
    check({23'd0, hz}, {23'd0, e_hz}, "hazard outputs");
    check(32'(issue_tag), 32'(m_tail), "issue_tag");
    check(32'(commit_valid), 32'(e_retire), "commit_valid");
    if (e_retire) begin
      // commit order must follow issue order
      check(commit_pc, m_pc[m_head], "commit_pc");
    end
    check(32'(insert_pc), 32'(m_insert), "insert_pc");
    if (m_insert) begin
      check(priv_pc, MTVEC_BASE, "priv_pc");
    end
    check(mepc, m_mepc, "mepc");
    check(mcause, m_mcause, "mcause");
  endtask

  task automatic advance_model();
    // trap registers take the head entry as it stands before the edge
    m_insert = e_flush;
    if (e_flush) begin
      m_mepc   = m_pc[m_head];
      m_mcause = expected_cause(m_exc[m_head]);
    end
    m_mis_ff = e_hz.npc_sel;
    if (wb_valid) begin
      m_exc[wb_req.tag] = wb_req.exc;
    end
    if (e_flush) begin
      clear_window();
    end else begin
      if (wb_valid && wb_req.wen) begin
        m_busy[wb_req.rd] = 1'b0;
      end
      if (e_fire && issue_req.wen && (issue_req.rd != '0)) begin
        m_busy[issue_req.rd] = 1'b1;
      end
      if (e_fire && (issue_req.fu_type == DIV_S)) begin
        m_div_cnt = DIV_LATENCY;
      end else if (m_div_cnt > 0) begin
        m_div_cnt--;
      end
      if (e_fire && (issue_req.fu_type == LOADSTORE_S)) begin
        m_ls_cnt = LS_LATENCY;
      end else if (m_ls_cnt > 0) begin
        m_ls_cnt--;
      end
      if (wb_valid) begin
        m_done[wb_req.tag] = 1'b1;
      end
      if (e_fire) begin
        m_pc[m_tail]    = issue_req.pc;
        m_rd[m_tail]    = issue_req.rd;
        m_wen[m_tail]   = issue_req.wen;
        m_valid[m_tail] = 1'b1;
        m_done[m_tail]  = 1'b0;
        m_tail          = (m_tail + 1) % CB_DEPTH;
        m_count++;
      end
      if (e_retire) begin
        m_valid[m_head] = 1'b0;
        m_head          = (m_head + 1) % CB_DEPTH;
        m_count--;
      end
    end
  endtask

  initial begin : stimulus
    logic new_req;
    logic fill;
    lfsr        = 32'h70b4;
    next_pc     = 32'h0000_1000;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_req   = '0;
    wb_valid    = 1'b0;
    wb_req      = '0;
    for (int i = 0; i < CB_DEPTH; i++) begin
      m_exc[i] = '0;
    end
    clear_window();
    m_mis_ff = 1'b0;
    m_insert = 1'b0;
    m_mepc   = '0;
    m_mcause = '0;
    {n_data, n_strct, n_csr, n_store} = '0;
    {n_full, n_commit, n_flush, n_redirect} = '0;
    new_req = 1'b1;
    repeat (RESET_CYCLES) @(negedge CLK);
    rst_n = 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      // short bursts without writebacks push the buffer to full
      fill = ((cyc % 256) < 32);
      // decode holds a stalled request unless the front end is squashed
      if (new_req) begin
        issue_req   = random_req(fill);
        issue_valid = (take_bits(2) != 0);
      end
      pick_writeback(fill);
      #1;
      compute_expected();
      compare_outputs();
      n_data     += int'(issue_valid && e_data);
      n_strct    += int'(issue_valid && e_strct);
      n_csr      += int'(issue_valid && issue_req.csr);
      n_store    += int'(issue_valid && e_store && (m_count != 0));
      n_full     += int'(m_count == CB_DEPTH);
      n_commit   += int'(e_retire);
      n_flush    += int'(e_flush);
      n_redirect += int'(e_hz.npc_sel);
      new_req = e_fire || e_hz.fetch_decode_flush || !issue_valid;
      advance_model();
      @(negedge CLK);
    end
    if ((n_data == 0) || (n_strct == 0) || (n_csr == 0) || (n_store == 0) ||
        (n_full == 0) || (n_commit == 0) || (n_flush == 0) || (n_redirect == 0)) begin
      $display("some behaviors were never exercised: data %0d struct %0d csr %0d store %0d",
               n_data, n_strct, n_csr, n_store);
      $display("full %0d commit %0d flush %0d redirect %0d",
               n_full, n_commit, n_flush, n_redirect);
      $display("FAIL: see errors above");
      $fatal(1, "coverage incomplete");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* design/ooo_issue_ctrl.sv */
module ooo_issue_ctrl
  import ooo_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        issue_valid,
  input  issue_req_t  issue_req,
  input  logic        wb_valid,
  input  wb_req_t     wb_req,
  output hazard_out_t hz,
  output cb_tag_t     issue_tag,
  output logic        commit_valid,
  output logic [31:0] commit_pc,
  output logic        insert_pc,
  output logic [31:0] priv_pc,
  output logic [31:0] mepc,
  output logic [31:0] mcause
);

  logic      issue_fire;
  logic      rs1_busy;
  logic      rs2_busy;
  logic      rd_busy;
  logic      busy_du;
  logic      busy_ls;
  logic      rob_full;
  logic      rob_empty;
  cb_flush_t cb_flush;

  ooo_hazard_unit u_hazard (
    .CLK(CLK), .rst_n(rst_n), .req(issue_req), .issue_valid(issue_valid),
    .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .rd_busy(rd_busy),
    .busy_du(busy_du), .busy_ls(busy_ls), .rob_full(rob_full),
    .rob_empty(rob_empty), .cb_flush(cb_flush), .insert_pc(insert_pc),
    .hz(hz), .issue_fire(issue_fire)
  );

  // exception flush clears every tracker of in-flight work
  reg_scoreboard u_scoreboard (
    .CLK(CLK), .rst_n(rst_n), .issue_fire(issue_fire), .req(issue_req),
    .wb_valid(wb_valid), .wb_req(wb_req), .flush(cb_flush.flush),
    .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .rd_busy(rd_busy)
  );

  fu_busy_tracker u_fu_busy (
    .CLK(CLK), .rst_n(rst_n), .issue_fire(issue_fire), .fu_type(issue_req.fu_type),
    .flush(cb_flush.flush), .busy_du(busy_du), .busy_ls(busy_ls)
  );

  completion_buffer u_cb (
    .CLK(CLK), .rst_n(rst_n), .issue_fire(issue_fire), .issue_pc(issue_req.pc),
    .wb_valid(wb_valid), .wb_req(wb_req), .issue_tag(issue_tag),
    .rob_full(rob_full), .rob_empty(rob_empty), .commit_valid(commit_valid),
    .commit_pc(commit_pc), .cb_flush(cb_flush)
  );

  prv_trap_ctrl u_trap (
    .CLK(CLK), .rst_n(rst_n), .cb_flush(cb_flush), .insert_pc(insert_pc),
    .priv_pc(priv_pc), .mepc(mepc), .mcause(mcause)
  );

endmodule

/* design/prv_trap_ctrl.sv */
module prv_trap_ctrl
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  cb_flush_t   cb_flush,
  output logic        insert_pc,
  output logic [31:0] priv_pc,
  output logic [31:0] mepc,
  output logic [31:0] mcause
);

  exc_flags_t  exc;
  logic [31:0] cause;

  // highest priority flag picks the cause
  always_comb begin
    exc = cb_flush.exc;
    if (exc.breakpoint) begin
      cause = CAUSE_BREAKPOINT;
    end else if (exc.fault_insn) begin
      cause = CAUSE_FAULT_INSN;
    end else if (exc.mal_insn) begin
      cause = CAUSE_MAL_INSN;
    end else if (exc.illegal_insn) begin
      cause = CAUSE_ILLEGAL_INSN;
    end else if (exc.env_m) begin
      cause = CAUSE_ENV_M;
    end else if (exc.mal_l) begin
      cause = CAUSE_MAL_L;
    end else if (exc.fault_l) begin
      cause = CAUSE_FAULT_L;
    end else if (exc.mal_s) begin
      cause = CAUSE_MAL_S;
    end else begin
      cause = CAUSE_FAULT_S;
    end
  end

  // trap entry one cycle after the flush, always to the direct vector
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      insert_pc <= 1'b0;
      mepc      <= '0;
      mcause    <= '0;
    end else begin
      insert_pc <= cb_flush.flush;
      if (cb_flush.flush) begin
        mepc   <= cb_flush.epc;
        mcause <= cause;
      end
    end
  end

  assign priv_pc = MTVEC_BASE;

endmodule

/* design/completion_buffer.sv */
module completion_buffer
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        issue_fire,
  input  logic [31:0] issue_pc,
  input  logic        wb_valid,
  input  wb_req_t     wb_req,
  output cb_tag_t     issue_tag,
  output logic        rob_full,
  output logic        rob_empty,
  output logic        commit_valid,
  output logic [31:0] commit_pc,
  output cb_flush_t   cb_flush
);

  // entry payload
  logic [31:0]   pc_q  [CB_DEPTH];
  exc_flags_t    exc_q [CB_DEPTH];

  // entry status and pointers
  logic [CB_DEPTH-1:0] done_q;
  cb_tag_t             head;
  cb_tag_t             tail;
  logic [CB_CNT_W-1:0] count;

  logic head_done;
  logic head_exc;
  logic retire;
  logic do_flush;

  // head is only meaningful while something is outstanding
  assign head_done = (count != '0) && done_q[head];
  assign head_exc  = |exc_q[head];

  // a clean done head retires, a faulting one flushes instead
  assign retire   = head_done && !head_exc;
  assign do_flush = head_done && head_exc;

  assign commit_valid = retire;
  assign commit_pc    = pc_q[head];

  always_comb begin
    cb_flush.flush = do_flush;
    cb_flush.epc   = pc_q[head];
    cb_flush.exc   = exc_q[head];
  end

  // next free slot doubles as the tag of the next issue
  assign issue_tag = tail;
  assign rob_full  = (count == CB_CNT_W'(CB_DEPTH));
  assign rob_empty = (count == '0);

  // pc captured at allocate, flags captured with the writeback
  always_ff @(posedge CLK) begin
    if (issue_fire) begin
      pc_q[tail] <= issue_pc;
    end
    if (wb_valid) begin
      exc_q[wb_req.tag] <= wb_req.exc;
    end
  end

  // an issue in the flush cycle is squashed with the rest of the window
  always_ff @(posedge CLK) begin
    if (!rst_n || do_flush) begin
      head   <= '0;
      tail   <= '0;
      count  <= '0;
      done_q <= '0;
    end else begin
      if (wb_valid) begin
        done_q[wb_req.tag] <= 1'b1;
      end
      // fresh entry starts not done
      if (issue_fire) begin
        done_q[tail] <= 1'b0;
        tail         <= tail + cb_tag_t'(1);
      end
      if (retire) begin
        head <= head + cb_tag_t'(1);
      end
      count <= count + CB_CNT_W'(issue_fire) - CB_CNT_W'(retire);
    end
  end

endmodule

/* design/fu_busy_tracker.sv */
module fu_busy_tracker
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
(
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     issue_fire,
  input  fu_type_t fu_type,
  input  logic     flush,
  output logic     busy_du,
  output logic     busy_ls
);

  // index 0 is the divider, index 1 the load/store unit
  logic [FU_CNT_W-1:0] cnt [2];
  logic [1:0]          load;

  always_comb begin
    load[0] = issue_fire && (fu_type == DIV_S);
    load[1] = issue_fire && (fu_type == LOADSTORE_S);
  end

  // structural stall prevents a load while the counter is still running
  always_ff @(posedge CLK) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n || flush) begin
        cnt[i] <= '0;
      end else if (load[i]) begin
        // each unit restarts at its own fixed latency
        cnt[i] <= (i == 0) ? FU_CNT_W'(DIV_LATENCY) : FU_CNT_W'(LS_LATENCY);
      end else if (cnt[i] != '0) begin
        cnt[i] <= cnt[i] - 1'b1;
      end
    end
  end

  assign busy_du = (cnt[0] != '0);
  assign busy_ls = (cnt[1] != '0);

endmodule

/* design/reg_scoreboard.sv */
module reg_scoreboard
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       issue_fire,
  input  issue_req_t req,
  input  logic       wb_valid,
  input  wb_req_t    wb_req,
  input  logic       flush,
  output logic       rs1_busy,
  output logic       rs2_busy,
  output logic       rd_busy
);

  // one pending-write bit per register, x0 has none
  logic [31:1] busy;
  logic [31:0] busy_vec;

  // x0 reads as never busy
  assign busy_vec = {busy, 1'b0};

  assign rs1_busy = busy_vec[req.rs1];
  assign rs2_busy = busy_vec[req.rs2];
  assign rd_busy  = busy_vec[req.rd];

  always_ff @(posedge CLK) begin
    if (!rst_n || flush) begin
      busy <= '0;
    end else begin
      for (int i = 1; i < 32; i++) begin
        // writeback releases the register
        if (wb_valid && wb_req.wen && (wb_req.rd == reg_idx_t'(i))) begin
          busy[i] <= 1'b0;
        end
        // a new writer claims it
        // rd_busy stall keeps this from colliding with the clear above
        if (issue_fire && req.wen && (req.rd == reg_idx_t'(i))) begin
          busy[i] <= 1'b1;
        end
      end
    end
  end

endmodule

/* design/ooo_hazard_unit.sv */
module ooo_hazard_unit
  import rv32i_types_pkg::*, ooo_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  issue_req_t  req,
  input  logic        issue_valid,
  input  logic        rs1_busy,
  input  logic        rs2_busy,
  input  logic        rd_busy,
  input  logic        busy_du,
  input  logic        busy_ls,
  input  logic        rob_full,
  input  logic        rob_empty,
  input  cb_flush_t   cb_flush,
  input  logic        insert_pc,
  output hazard_out_t hz,
  output logic        issue_fire
);

  logic src_a_hazard;
  logic src_b_hazard;
  logic dst_hazard;
  logic data_hazard;
  logic structural_hazard;
  logic store;
  logic stall;
  logic npc_sel;
  logic mispredict_ff;

  // operand a only matters when it is read from the register file
  always_comb begin
    case (req.source_a_sel)
      2'd0, 2'd1: src_a_hazard = rs1_busy;
      default:    src_a_hazard = 1'b0;
    endcase
  end

  // same rule for operand b
  always_comb begin
    case (req.source_b_sel)
      2'd0, 2'd1: src_b_hazard = rs2_busy;
      default:    src_b_hazard = 1'b0;
    endcase
  end

  // waw on a pending destination only if this one writes back
  assign dst_hazard  = rd_busy & req.wen;
  assign data_hazard = src_a_hazard | src_b_hazard | dst_hazard;

  // divider and load/store unit accept one op at a time
  assign structural_hazard = ((req.fu_type == DIV_S) & busy_du) |
                             ((req.fu_type == LOADSTORE_S) & busy_ls);

  // stores wait for every older instruction to commit
  assign store = (req.fu_type == LOADSTORE_S) && (req.source_a_sel == 2'd1);

  assign stall = req.csr | rob_full | data_hazard | structural_hazard |
                 (store & ~rob_empty) | mispredict_ff;

  assign issue_fire = issue_valid & ~stall;

  // redirect on a mispredicted branch as it leaves decode
  assign npc_sel = issue_fire & req.branch & req.mispredict;

  // hold decode one extra cycle while the redirected fetch settles
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= npc_sel;
    end
  end

  always_comb begin
    hz.pc_en                = ~stall;
    hz.stall_fetch_decode   = stall;
    hz.data_hazard          = data_hazard;
    hz.hazard               = data_hazard | structural_hazard;
    hz.npc_sel              = npc_sel;
    hz.csr_flush            = req.csr;
    // front end squash on redirect, trap entry, csr or exception flush
    hz.fetch_decode_flush   = npc_sel | insert_pc | req.csr | cb_flush.flush;
    hz.decode_execute_flush = npc_sel | insert_pc | cb_flush.flush;
    hz.execute_commit_flush = req.csr | cb_flush.flush;
  end

endmodule

/* design/ooo_ctrl_pkg.sv */
package ooo_ctrl_pkg;
  import rv32i_types_pkg::*;

  // completion buffer sizing, depth must be a power of two for pointer wrap
  localparam int CB_DEPTH = 8;
  localparam int CB_CNT_W = $clog2(CB_DEPTH + 1);
  typedef logic [$clog2(CB_DEPTH)-1:0] cb_tag_t;

  // fixed busy time of the multi-cycle units after issue
  localparam int DIV_LATENCY = 8;
  localparam int LS_LATENCY  = 3;
  localparam int FU_CNT_W    = $clog2(((DIV_LATENCY > LS_LATENCY) ?
                                       DIV_LATENCY : LS_LATENCY) + 1);

  // machine trap vector and standard cause codes
  localparam logic [31:0] MTVEC_BASE         = 32'h0000_0100;
  localparam logic [31:0] CAUSE_MAL_INSN     = 32'd0;
  localparam logic [31:0] CAUSE_FAULT_INSN   = 32'd1;
  localparam logic [31:0] CAUSE_ILLEGAL_INSN = 32'd2;
  localparam logic [31:0] CAUSE_BREAKPOINT   = 32'd3;
  localparam logic [31:0] CAUSE_MAL_L        = 32'd4;
  localparam logic [31:0] CAUSE_FAULT_L      = 32'd5;
  localparam logic [31:0] CAUSE_MAL_S        = 32'd6;
  localparam logic [31:0] CAUSE_FAULT_S      = 32'd7;
  localparam logic [31:0] CAUSE_ENV_M        = 32'd11;

  // instruction offered by decode to the issue stage
  typedef struct packed {
    logic [31:0] pc;
    fu_type_t    fu_type;
    src_sel_t    source_a_sel;
    src_sel_t    source_b_sel;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic        wen;
    logic        csr;
    logic        branch;
    logic        mispredict;
  } issue_req_t;

  // completion report from the execution side
  typedef struct packed {
    cb_tag_t    tag;
    reg_idx_t   rd;
    logic       wen;
    exc_flags_t exc;
  } wb_req_t;

  // exception flush raised at the head of the completion buffer
  typedef struct packed {
    logic        flush;
    logic [31:0] epc;
    exc_flags_t  exc;
  } cb_flush_t;

  // stall and flush decisions of the hazard unit
  typedef struct packed {
    logic pc_en;
    logic stall_fetch_decode;
    logic data_hazard;
    logic hazard;
    logic npc_sel;
    logic fetch_decode_flush;
    logic decode_execute_flush;
    logic execute_commit_flush;
    logic csr_flush;
  } hazard_out_t;

endpackage

/* design/rv32i_types_pkg.sv */
package rv32i_types_pkg;

  // functional unit selected by decode
  typedef enum logic [1:0] {
    ARITH_S     = 2'd0,
    MUL_S       = 2'd1,
    DIV_S       = 2'd2,
    LOADSTORE_S = 2'd3
  } fu_type_t;

  // architectural register number, x0 is hardwired zero
  typedef logic [4:0] reg_idx_t;

  // operand source select
  // 0 and 1 read the register file, 2 and 3 read an immediate or the pc
  typedef logic [1:0] src_sel_t;

  // exception flags carried with an instruction to commit
  typedef struct packed {
    logic fault_insn;
    logic mal_insn;
    logic illegal_insn;
    logic fault_l;
    logic mal_l;
    logic fault_s;
    logic mal_s;
    logic breakpoint;
    logic env_m;
  } exc_flags_t;

endpackage
